// File: Makefile
VERILATOR  ?= verilator
TOP        ?= bob_tb
FILELIST   ?= filelist.f
OBJ_DIR    ?= obj_dir
PASS_MSG   ?= Simulation finished: PASS
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: filelist.f
hw/bob_pkg.sv
hw/bob_ram.sv
hw/bob_read_arb.sv
hw/bob_tracker.sv
hw/bob_resolver.sv
hw/bob_retirer.sv
hw/bob_top.sv
testbench/bob_props.sv
testbench/bob_tb.sv

// File: hw/bob_pkg.sv
`default_nettype none

package bob_pkg;

  localparam int bob_depth_default = 16;
  localparam int bob_tag_w = $clog2(bob_depth_default);

  typedef logic [31:0] bob_target_t;

  typedef logic thread_t;

  // written at dispatch
  typedef struct packed {
    bob_target_t target;
    logic        taken;
  } pred_rec_t;

  // written by the resolver once the branch executes
  typedef struct packed {
    bob_target_t target;
    logic        taken;
    logic        mispredict;
  } outcome_rec_t;

endpackage

`default_nettype wire

// File: hw/bob_ram.sv
`timescale 1ns/1ps
`default_nettype none

module bob_ram import bob_pkg::*; #(
  parameter int DEPTH = bob_depth_default,
  parameter type payload_t = pred_rec_t,
  localparam int TW = $clog2(DEPTH)
) (
  input  logic          clk,

  input  logic          read_en,
  input  logic [TW-1:0] read_addr,
  output payload_t      read_data,

  input  logic          write_en,
  input  logic [TW-1:0] write_addr,
  input  payload_t      write_data
);

  payload_t      mem [DEPTH];
  logic [TW-1:0] read_addr_q;

  assign read_data = mem[read_addr_q]; // async read off the held address

  always_ff @(posedge clk) begin
    if (write_en) begin
      mem[write_addr] <= write_data;
    end
    if (read_en) begin
      read_addr_q <= read_addr;
    end
  end

endmodule

`default_nettype wire

// File: hw/bob_read_arb.sv
`timescale 1ns/1ps
`default_nettype none

module bob_read_arb import bob_pkg::*; #(
  parameter int DEPTH = bob_depth_default,
  localparam int TW = $clog2(DEPTH)
) (
  input  logic          clk,
  input  logic          rst,

  input  logic          req_resolve,
  input  logic          req_retire,
  input  logic [TW-1:0] addr_resolve,
  input  logic [TW-1:0] addr_retire,

  output logic          gnt_resolve,
  output logic          gnt_retire,

  output logic          read_en,
  output logic [TW-1:0] read_addr
);

  logic last_retire; // retirer won the last contested or uncontested grant

  assign gnt_resolve = req_resolve & (~req_retire | last_retire);
  assign gnt_retire  = req_retire & (~req_resolve | ~last_retire);

  assign read_en   = gnt_resolve | gnt_retire;
  assign read_addr = gnt_retire ? addr_retire : addr_resolve;

  always_ff @(posedge clk) begin
    if (rst) begin
      last_retire <= 1'b0;
    end else if (read_en) begin
      last_retire <= gnt_retire;
    end
  end

endmodule

`default_nettype wire

// File: hw/bob_resolver.sv
`timescale 1ns/1ps
`default_nettype none

module bob_resolver import bob_pkg::*; #(
  parameter int DEPTH = bob_depth_default,
  localparam int TW = $clog2(DEPTH)
) (
  input  logic          clk,
  input  logic          rst,

  input  logic          resolve_en,
  input  logic [TW-1:0] resolve_tag,
  input  thread_t       resolve_thread,
  input  logic          resolve_taken,
  input  bob_target_t   resolve_target,
  output logic          resolve_busy,

  output logic          req,
  input  logic          gnt,
  output logic [TW-1:0] read_tag,
  input  pred_rec_t     pred,

  output logic          out_we,
  output logic [TW-1:0] out_tag,
  output outcome_rec_t  out_rec,

  output logic          mark_resolved,
  output logic          mispredict,
  output logic [TW-1:0] mispredict_tag,

  input  logic          flush_en,
  input  thread_t       flush_thread
);

  logic          req_q;    // waiting for the read port
  logic          cmp_q;    // predicted record is on pred this cycle
  logic          killed_q; // thread flushed while pending
  logic [TW-1:0] tag_q;
  thread_t       thread_q;
  logic          taken_q;
  bob_target_t   target_q;
  logic          accept;
  logic          flush_hit;
  logic          mis;

  assign resolve_busy = req_q;
  assign accept       = resolve_en & ~req_q;
  assign flush_hit    = flush_en & (flush_thread == thread_q);

  assign req      = req_q;
  assign read_tag = tag_q;

  // target only matters when the branch was taken
  assign mis = (taken_q != pred.taken) | (taken_q & (target_q != pred.target));

  always_comb begin
    out_rec.target     = target_q;
    out_rec.taken      = taken_q;
    out_rec.mispredict = mis;
  end

  assign out_we  = cmp_q;
  assign out_tag = tag_q;

  assign mark_resolved  = cmp_q & ~killed_q & ~flush_hit;
  assign mispredict     = mark_resolved & mis;
  assign mispredict_tag = tag_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      req_q    <= 1'b0;
      cmp_q    <= 1'b0;
      killed_q <= 1'b0;
    end else begin
      cmp_q <= req_q & gnt;
      if (accept) begin
        req_q    <= 1'b1;
        killed_q <= flush_en & (flush_thread == resolve_thread);
      end else begin
        if (gnt) begin
          req_q <= 1'b0;
        end
        if (flush_hit) begin
          killed_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      tag_q    <= resolve_tag;
      thread_q <= resolve_thread;
      taken_q  <= resolve_taken;
      target_q <= resolve_target;
    end
  end

endmodule

`default_nettype wire

// File: hw/bob_retirer.sv
`timescale 1ns/1ps
`default_nettype none

module bob_retirer import bob_pkg::*; #(
  parameter int DEPTH = bob_depth_default,
  localparam int TW = $clog2(DEPTH)
) (
  input  logic          clk,
  input  logic          rst,

  input  logic          retire_en,
  input  logic          head_ready,
  input  logic [TW-1:0] head_tag,
  input  thread_t       head_thread,

  output logic          req,
  output logic          retire_take,
  input  logic          gnt,

  input  pred_rec_t     pred,
  input  outcome_rec_t  outcome,

  output logic          retire_valid,
  output logic [TW-1:0] retire_tag,
  output thread_t       retire_thread,
  output pred_rec_t     retire_pred,
  output outcome_rec_t  retire_outcome,

  input  logic          flush_en,
  input  thread_t       flush_thread
);

  logic          pend_q; // both memories hold the taken entry's address
  logic [TW-1:0] tag_q;
  thread_t       thread_q;
  logic          take_flushed;
  logic          pend_flushed;

  assign req         = retire_en & head_ready;
  assign retire_take = gnt;

  assign take_flushed = flush_en & (flush_thread == head_thread);
  assign pend_flushed = flush_en & (flush_thread == thread_q);

  assign retire_valid   = pend_q & ~pend_flushed;
  assign retire_tag     = tag_q;
  assign retire_thread  = thread_q;
  assign retire_pred    = pred;
  assign retire_outcome = outcome;

  always_ff @(posedge clk) begin
    if (rst) begin
      pend_q <= 1'b0;
    end else begin
      pend_q <= gnt & ~take_flushed; // flushed on the grant edge too
    end
  end

  always_ff @(posedge clk) begin
    if (gnt) begin
      tag_q    <= head_tag;
      thread_q <= head_thread;
    end
  end

endmodule

`default_nettype wire

// File: hw/bob_top.sv
`timescale 1ns/1ps
`default_nettype none

module bob_top import bob_pkg::*; #(
  parameter int BOB_DEPTH = bob_depth_default,
  localparam int TW = $clog2(BOB_DEPTH)
) (
  input  logic          clk,
  input  logic          rst,

  input  logic          alloc_en,
  input  thread_t       alloc_thread,
  input  pred_rec_t     alloc_pred,
  output logic          full,
  output logic [TW-1:0] alloc_tag,

  input  logic          resolve_en,
  input  logic [TW-1:0] resolve_tag,
  input  logic          resolve_taken,
  input  bob_target_t   resolve_target,
  output logic          resolve_busy,
  output logic          mispredict,
  output logic [TW-1:0] mispredict_tag,

  input  logic          flush_en,
  input  thread_t       flush_thread,

  input  logic          retire_en,
  output logic          retire_valid,
  output logic [TW-1:0] retire_tag,
  output thread_t       retire_thread,
  output pred_rec_t     retire_pred,
  output outcome_rec_t  retire_outcome
);

  logic          alloc_ok;
  logic          mark_resolved;
  logic [TW-1:0] mark_tag;
  logic          retire_take;
  logic          head_ready;
  logic [TW-1:0] head_tag;
  thread_t       head_thread;
  thread_t       resolve_thread;

  logic          req_resolve;
  logic          req_retire;
  logic          gnt_resolve;
  logic          gnt_retire;
  logic          read_en;
  logic [TW-1:0] read_addr;
  logic [TW-1:0] read_tag;
  pred_rec_t     pred_data;
  outcome_rec_t  outcome_data;
  logic          out_we;
  outcome_rec_t  out_rec;

  bob_tracker #(.DEPTH(BOB_DEPTH)) tracker (
    .clk           (clk),
    .rst           (rst),
    .alloc_en      (alloc_en),
    .alloc_thread  (alloc_thread),
    .alloc_tag     (alloc_tag),
    .alloc_ok      (alloc_ok),
    .full          (full),
    .mark_resolved (mark_resolved),
    .mark_tag      (mark_tag),
    .retire_take   (retire_take),
    .head_ready    (head_ready),
    .head_tag      (head_tag),
    .head_thread   (head_thread),
    .lookup_tag    (resolve_tag),
    .thread_of_tag (resolve_thread),
    .flush_en      (flush_en),
    .flush_thread  (flush_thread)
  );

  bob_read_arb #(.DEPTH(BOB_DEPTH)) read_arb (
    .clk          (clk),
    .rst          (rst),
    .req_resolve  (req_resolve),
    .req_retire   (req_retire),
    .addr_resolve (read_tag),
    .addr_retire  (head_tag),
    .gnt_resolve  (gnt_resolve),
    .gnt_retire   (gnt_retire),
    .read_en      (read_en),
    .read_addr    (read_addr)
  );

  bob_resolver #(.DEPTH(BOB_DEPTH)) resolver (
    .clk            (clk),
    .rst            (rst),
    .resolve_en     (resolve_en),
    .resolve_tag    (resolve_tag),
    .resolve_thread (resolve_thread),
    .resolve_taken  (resolve_taken),
    .resolve_target (resolve_target),
    .resolve_busy   (resolve_busy),
    .req            (req_resolve),
    .gnt            (gnt_resolve),
    .read_tag       (read_tag),
    .pred           (pred_data),
    .out_we         (out_we),
    .out_tag        (mark_tag),
    .out_rec        (out_rec),
    .mark_resolved  (mark_resolved),
    .mispredict     (mispredict),
    .mispredict_tag (mispredict_tag),
    .flush_en       (flush_en),
    .flush_thread   (flush_thread)
  );

  bob_retirer #(.DEPTH(BOB_DEPTH)) retirer (
    .clk            (clk),
    .rst            (rst),
    .retire_en      (retire_en),
    .head_ready     (head_ready),
    .head_tag       (head_tag),
    .head_thread    (head_thread),
    .req            (req_retire),
    .retire_take    (retire_take),
    .gnt            (gnt_retire),
    .pred           (pred_data),
    .outcome        (outcome_data),
    .retire_valid   (retire_valid),
    .retire_tag     (retire_tag),
    .retire_thread  (retire_thread),
    .retire_pred    (retire_pred),
    .retire_outcome (retire_outcome),
    .flush_en       (flush_en),
    .flush_thread   (flush_thread)
  );

  // read port shared by resolver and retirer
  bob_ram #(.DEPTH(BOB_DEPTH), .payload_t(pred_rec_t)) pred_ram (
    .clk        (clk),
    .read_en    (read_en),
    .read_addr  (read_addr),
    .read_data  (pred_data),
    .write_en   (alloc_ok),
    .write_addr (alloc_tag),
    .write_data (alloc_pred)
  );

  // read only by the retirer, loaded on its grant
  bob_ram #(.DEPTH(BOB_DEPTH), .payload_t(outcome_rec_t)) outcome_ram (
    .clk        (clk),
    .read_en    (retire_take),
    .read_addr  (head_tag),
    .read_data  (outcome_data),
    .write_en   (out_we),
    .write_addr (mark_tag),
    .write_data (out_rec)
  );

endmodule

`default_nettype wire

// File: hw/bob_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module bob_tracker import bob_pkg::*; #(
  parameter int DEPTH = bob_depth_default,
  localparam int TW = $clog2(DEPTH),
  localparam int CW = $clog2(DEPTH + 1)
) (
  input  logic          clk,
  input  logic          rst,

  input  logic          alloc_en,
  input  thread_t       alloc_thread,
  output logic [TW-1:0] alloc_tag,
  output logic          alloc_ok,
  output logic          full,

  input  logic          mark_resolved,
  input  logic [TW-1:0] mark_tag,

  input  logic          retire_take,
  output logic          head_ready,
  output logic [TW-1:0] head_tag,
  output thread_t       head_thread,

  input  logic [TW-1:0] lookup_tag,
  output thread_t       thread_of_tag,

  input  logic          flush_en,
  input  thread_t       flush_thread
);

  logic [DEPTH-1:0] live;
  logic [DEPTH-1:0] resolved;
  thread_t          entry_thread [DEPTH];

  logic [TW-1:0] head;
  logic [TW-1:0] tail;
  logic [CW-1:0] count; // dead entries still count until skipped
  logic          in_flight;
  logic          head_skip;
  logic          head_move;

  function automatic logic [TW-1:0] next_ptr(input logic [TW-1:0] p);
    if (p == TW'(DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  assign full      = (count == CW'(DEPTH));
  assign alloc_ok  = alloc_en & ~full;
  assign alloc_tag = tail;

  assign head_tag    = head;
  assign head_thread = entry_thread[head];
  assign head_ready  = live[head] & resolved[head] & ~in_flight;

  assign head_skip = (count != '0) & ~live[head]; // flushed entry at head
  assign head_move = retire_take | head_skip;

  assign thread_of_tag = entry_thread[lookup_tag];

  always_ff @(posedge clk) begin
    if (rst) begin
      live      <= '0;
      head      <= '0;
      tail      <= '0;
      count     <= '0;
      in_flight <= 1'b0;
    end else begin
      in_flight <= retire_take;
      if (flush_en) begin
        for (int i = 0; i < DEPTH; i++) begin
          if (entry_thread[i] == flush_thread) begin
            live[i] <= 1'b0;
          end
        end
      end
      if (retire_take) begin
        live[head] <= 1'b0;
      end
      if (alloc_ok) begin
        live[tail] <= 1'b1; // new entry survives a same-cycle flush
        tail       <= next_ptr(tail);
      end
      if (head_move) begin
        head <= next_ptr(head);
      end
      count <= count + CW'(alloc_ok) - CW'(head_move);
    end
  end

  always_ff @(posedge clk) begin
    if (alloc_ok) begin
      entry_thread[tail] <= alloc_thread;
      resolved[tail]     <= 1'b0;
    end
    if (mark_resolved) begin
      resolved[mark_tag] <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: testbench/bob_props.sv
`timescale 1ns/1ps
`default_nettype none

module bob_props #(
  parameter int TW = 1
) (
  input logic          clk,
  input logic          rst,
  input logic          retire_valid,
  input logic          gnt_resolve,
  input logic          gnt_retire,
  input logic          alloc_en,
  input logic          full,
  input logic [TW-1:0] alloc_tag
);

  no_retire_after_reset: assert property (@(posedge clk) $fell(rst) |-> !retire_valid)
    else $error("retire_valid high in the first cycle after reset");

  // read port goes to one side at a time
  one_grant: assert property (@(posedge clk) disable iff (rst)
    !(gnt_resolve && gnt_retire))
    else $error("resolver and retirer granted together");

  // tail only moves on an accepted allocation
  no_alloc_when_full: assert property (@(posedge clk) disable iff (rst)
    (alloc_en && full) |=> $stable(alloc_tag))
    else $error("allocation accepted while full");

endmodule

bind bob_top bob_props #(.TW(TW)) props_inst (
  .clk          (clk),
  .rst          (rst),
  .retire_valid (retire_valid),
  .gnt_resolve  (gnt_resolve),
  .gnt_retire   (gnt_retire),
  .alloc_en     (alloc_en),
  .full         (full),
  .alloc_tag    (alloc_tag)
);

`default_nettype wire

// File: testbench/bob_tb.sv
`timescale 1ns/1ps
`default_nettype none

module bob_tb import bob_pkg::*; ();

  localparam int bob_depth = 4; // small buffer so full and wrap show up early
  localparam int tag_w = $clog2(bob_depth);
  localparam int resolve_timeout = 20;
  localparam int drain_timeout = 100;

  typedef struct {
    logic [tag_w-1:0] tag;
    thread_t          thread;
    pred_rec_t        pred;
    logic             resolved;
    outcome_rec_t     outcome;
  } model_entry_t;

  logic             clk;
  logic             rst;
  logic             alloc_en;
  thread_t          alloc_thread;
  pred_rec_t        alloc_pred;
  logic             full;
  logic [tag_w-1:0] alloc_tag;
  logic             resolve_en;
  logic [tag_w-1:0] resolve_tag;
  logic             resolve_taken;
  bob_target_t      resolve_target;
  logic             resolve_busy;
  logic             mispredict;
  logic [tag_w-1:0] mispredict_tag;
  logic             flush_en;
  thread_t          flush_thread;
  logic             retire_en;
  logic             retire_valid;
  logic [tag_w-1:0] retire_tag;
  thread_t          retire_thread;
  pred_rec_t        retire_pred;
  outcome_rec_t     retire_outcome;

  model_entry_t model_q[$]; // live entries in allocation order
  bit           fail_shown;
  bit           pass_shown;

  bob_top #(.BOB_DEPTH(bob_depth)) bob_top_inst (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stop_failed();
    fail_shown = 1'b1;
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic fail_value(input string msg);
    $display("ERR %0t: %s", $time, msg);
    stop_failed();
  endtask

  task automatic fail_event(input string msg);
    $display("%s", msg);
    stop_failed();
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic alloc_branch(input thread_t thread, input bob_target_t target,
                              input logic taken, input logic exp_ok,
                              input logic [tag_w-1:0] exp_tag);
    model_entry_t ent;
    logic         accepted;
    alloc_en = 1'b1;
    alloc_thread = thread;
    alloc_pred.target = target;
    alloc_pred.taken = taken;
    #6;
    accepted = ~full;
    assert (accepted == exp_ok)
      else fail_value($sformatf("alloc accepted=%0b, expected %0b", accepted, exp_ok));
    if (accepted) begin
      assert (alloc_tag == exp_tag)
        else fail_value($sformatf("alloc tag %0d, expected %0d", alloc_tag, exp_tag));
      ent.tag = alloc_tag;
      ent.thread = thread;
      ent.pred = alloc_pred;
      ent.resolved = 1'b0;
      ent.outcome = '0;
      model_q.push_back(ent);
    end
    next_cycle();
    alloc_en = 1'b0;
  endtask

  task automatic resolve_branch(input logic [tag_w-1:0] tag, input logic taken,
                                input bob_target_t target, input logic exp_mis,
                                input logic [tag_w-1:0] exp_tag);
    int waited;
    waited = 0;
    while (resolve_busy && waited < resolve_timeout) begin
      next_cycle();
      waited++;
    end
    assert (!resolve_busy) else fail_event("resolver never became free for a new branch");
    resolve_en = 1'b1;
    resolve_tag = tag;
    resolve_taken = taken;
    resolve_target = target;
    next_cycle();
    resolve_en = 1'b0;
    assert (resolve_busy)
      else fail_event($sformatf("resolution of tag %0d was not accepted", tag));
    waited = 0;
    while (resolve_busy && waited < resolve_timeout) begin
      next_cycle();
      waited++;
    end
    assert (!resolve_busy)
      else fail_event($sformatf("resolution of tag %0d never completed", tag));
    // compare cycle
    assert (mispredict == exp_mis)
      else fail_value($sformatf("tag %0d mispredict=%0b, expected %0b", tag, mispredict, exp_mis));
    if (exp_mis) begin
      assert (mispredict_tag == exp_tag)
        else fail_value($sformatf("mispredict tag %0d, expected %0d", mispredict_tag, exp_tag));
    end
    for (int i = 0; i < model_q.size(); i++) begin
      if (model_q[i].tag == tag) begin
        model_q[i].resolved = 1'b1;
        model_q[i].outcome.target = target;
        model_q[i].outcome.taken = taken;
        model_q[i].outcome.mispredict = exp_mis;
      end
    end
  endtask

  task automatic squash_thread(input thread_t thread);
    flush_en = 1'b1;
    flush_thread = thread;
    for (int i = model_q.size() - 1; i >= 0; i--) begin
      if (model_q[i].thread == thread) begin
        model_q.delete(i);
      end
    end
    next_cycle();
    flush_en = 1'b0;
  endtask

  task automatic check_retire();
    model_entry_t want;
    assert (model_q.size() != 0) else fail_event("retire_valid with no live entry left");
    want = model_q.pop_front();
    assert (want.resolved)
      else fail_event($sformatf("tag %0d retired before it was resolved", want.tag));
    assert (retire_tag == want.tag && retire_thread == want.thread)
      else fail_value($sformatf("retired tag %0d thread %0b, expected tag %0d thread %0b",
                                retire_tag, retire_thread, want.tag, want.thread));
    assert (retire_pred == want.pred)
      else fail_value($sformatf("tag %0d pred %h, expected %h", want.tag, retire_pred,
                                want.pred));
    assert (retire_outcome == want.outcome)
      else fail_value($sformatf("tag %0d outcome %h, expected %h", want.tag, retire_outcome,
                                want.outcome));
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (model_q.size() != 0 && waited < drain_timeout) begin
      next_cycle();
      waited++;
    end
    assert (model_q.size() == 0)
      else fail_event($sformatf("%0d entries never retired", model_q.size()));
  endtask

  always @(negedge clk) begin
    if (!rst && retire_valid) begin
      check_retire();
    end
  end

  initial begin
    int          fd;
    int          n;
    int          ch;
    string       op;
    logic [31:0] a, b, c, d, e;
    rst = 1'b1;
    alloc_en = 1'b0;
    alloc_thread = 1'b0;
    alloc_pred = '0;
    resolve_en = 1'b0;
    resolve_tag = '0;
    resolve_taken = 1'b0;
    resolve_target = '0;
    flush_en = 1'b0;
    flush_thread = 1'b0;
    retire_en = 1'b0;
    repeat (3) @(posedge clk);
    #2;
    rst = 1'b0;
    fd = $fopen("testbench/bob_tests.txt", "r");
    assert (fd != 0) else fail_event("cannot open testbench/bob_tests.txt");
    while ($fscanf(fd, "%s", op) == 1) begin
      if (op.substr(0, 0) == "#") begin
        ch = $fgetc(fd);
        while (ch != 10 && ch != -1) begin
          ch = $fgetc(fd);
        end
      end else begin
        n = $fscanf(fd, "%h %h %h %h %h", a, b, c, d, e);
        assert (n == 5) else fail_event($sformatf("short '%s' line in the test file", op));
        case (op)
          "alloc": alloc_branch(a[0], b, c[0], d[0], e[tag_w-1:0]);
          "resolve": resolve_branch(a[tag_w-1:0], b[0], c, d[0], e[tag_w-1:0]);
          "flush": squash_thread(a[0]);
          "retire_on": begin
            retire_en = 1'b1;
            next_cycle();
          end
          "retire_off": begin
            retire_en = 1'b0;
            next_cycle();
          end
          "idle": repeat (a) next_cycle();
          "expect_full": begin
            assert (full == a[0])
              else fail_value($sformatf("full=%0b, expected %0b", full, a[0]));
          end
          default: fail_event($sformatf("unknown operation '%s' in the test file", op));
        endcase
      end
    end
    $fclose(fd);
    wait_drained();
    repeat (4) next_cycle();
    pass_shown = 1'b1;
    $display("Simulation finished: PASS");
    $finish;
  end

  // a run stopped by a failing assertion elsewhere
  final begin
    if (!pass_shown && !fail_shown) begin
      $display("Simulation finished: FAIL");
    end
  end

endmodule

`default_nettype wire

// File: testbench/bob_tests.txt
# columns: op a b c d e, all hex; alloc = thread target taken accept tag
# resolve = tag taken target mispredict tag; flush, idle, expect_full use a only
alloc       0 00001000 1        1 0
alloc       1 00002000 0        1 1
alloc       0 00003000 1        1 2
alloc       1 00004000 1        1 3
expect_full 1 0        0        0 0
alloc       0 00005000 0        0 0
resolve     2 1        00003080 1 2
resolve     0 1        00001000 0 0
resolve     3 0        00004000 1 3
resolve     1 0        00005555 0 1
retire_on   0 0        0        0 0
retire_off  0 0        0        0 0
expect_full 0 0        0        0 0
alloc       0 00005000 0        1 0
resolve     0 0        00005000 0 0
flush       1 0        0        0 0
retire_on   0 0        0        0 0
idle        a 0        0        0 0
alloc       0 00006000 1        1 1
alloc       1 00007000 1        1 2
alloc       0 00008000 0        1 3
alloc       1 00009000 1        1 0
resolve     1 1        00006000 0 1
resolve     2 1        00007004 1 2
resolve     3 1        00008000 1 3
resolve     0 1        00009000 0 0
